/* Bender.yml */
package:
  name: pwm_controller

sources:
  - include_dirs:
      - include
    files:
      - rtl/pwm_mode_pkg.sv
      - rtl/pwm_regmap_pkg.sv
      - rtl/pwm_standard_gen.sv
      - rtl/pwm_heartbeat_gen.sv
      - rtl/pwm_channel.sv
      - rtl/pwm_regfile.sv
      - rtl/pwm_controller.sv
      - target: simulation
        files:
          - sim/pwm_controller_tb.sv

/* include/pwm_defines.svh */
// widths and counter step shared by the PWM RTL; include wherever a width is needed
`ifndef PWM_DEFINES_SVH
`define PWM_DEFINES_SVH

// period, threshold, duty and counter width
`define PWM_RESOLUTION 32

// heartbeat ramp step width
`define PWM_STEP_WIDTH 12

// bus byte offset width, only the low bits of the SoC address
`define PWM_ADDR_WIDTH 6

// bus data width
`define PWM_DATA_WIDTH 32

// period counter increment per clock
`define PWM_COUNT_STEP 1

`endif

/* rtl/pwm_channel.sv */
// one PWM channel that decodes the mode, runs both generators and registers the selected output
`timescale 1ns/100ps
`default_nettype none

`include "pwm_defines.svh"

module pwm_channel import pwm_mode_pkg::*; (
    input  wire logic                       clk_i,
    input  wire logic                       rst_i,
    input  wire pwm_mode_e                  mode_i,
    input  wire logic [`PWM_RESOLUTION-1:0] period_i,
    input  wire logic [`PWM_RESOLUTION-1:0] thresh_a_i,
    input  wire logic [`PWM_RESOLUTION-1:0] thresh_b_i,
    input  wire logic [`PWM_STEP_WIDTH-1:0] step_i,
    output logic                            pwm_o
);

    logic std_en;
    logic hb_en;
    logic std_pwm;
    logic hb_pwm;

    assign std_en = (mode_i == MODE_STANDARD);
    assign hb_en  = (mode_i == MODE_HEARTBEAT); // the unused generator sits cleared

    pwm_standard_gen pwm_standard_gen_inst (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .enable_i (std_en),
        .period_i (period_i),
        .thresh_i (thresh_a_i),
        .pwm_o    (std_pwm)
    );

    pwm_heartbeat_gen pwm_heartbeat_gen_inst (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .enable_i   (hb_en),
        .period_i   (period_i),
        .thresh_a_i (thresh_a_i),
        .thresh_b_i (thresh_b_i),
        .step_i     (step_i),
        .pwm_o      (hb_pwm)
    );

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pwm_o <= 1'b0;
        end else begin
            case (mode_i)
                MODE_STANDARD:  pwm_o <= std_pwm;
                MODE_HEARTBEAT: pwm_o <= hb_pwm;
                default:        pwm_o <= 1'b0; // idle and the spare code 3
            endcase
        end
    end

    // idle also clears both generators within one clock
    assert property (@(posedge clk_i) disable iff (rst_i)
        (mode_i == MODE_IDLE) |=> !pwm_o && !std_pwm && !hb_pwm)
        else $error("channel output high one cycle after idle mode");

endmodule

`default_nettype wire

/* rtl/pwm_controller.sv */
// top level of the two-channel PWM peripheral, connects the register file to both channels
`timescale 1ns/100ps
`default_nettype none

`include "pwm_defines.svh"

module pwm_controller import pwm_mode_pkg::*; (
    input  wire logic                       clk_i,
    input  wire logic                       rst_i,
    input  wire logic [`PWM_ADDR_WIDTH-1:0] bus_addr_i,
    input  wire logic [`PWM_DATA_WIDTH-1:0] bus_wdata_i,
    input  wire logic                       bus_valid_i,
    input  wire logic                       bus_we_i,
    output logic      [`PWM_DATA_WIDTH-1:0] bus_rdata_o,
    output logic                            bus_rvalid_o,
    output logic                            pwm0_o,
    output logic                            pwm1_o
);

    pwm_mode_e                  mode_0;
    pwm_mode_e                  mode_1;
    logic [`PWM_RESOLUTION-1:0] period_0;
    logic [`PWM_RESOLUTION-1:0] period_1;
    logic [`PWM_RESOLUTION-1:0] thresh_a_0;
    logic [`PWM_RESOLUTION-1:0] thresh_b_0;
    logic [`PWM_RESOLUTION-1:0] thresh_a_1;
    logic [`PWM_RESOLUTION-1:0] thresh_b_1;
    logic [`PWM_STEP_WIDTH-1:0] step_0;
    logic [`PWM_STEP_WIDTH-1:0] step_1;

    pwm_regfile pwm_regfile_inst (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .bus_addr_i   (bus_addr_i),
        .bus_wdata_i  (bus_wdata_i),
        .bus_valid_i  (bus_valid_i),
        .bus_we_i     (bus_we_i),
        .pwm0_i       (pwm0_o), // pin levels back for REG_OUT reads
        .pwm1_i       (pwm1_o),
        .bus_rdata_o  (bus_rdata_o),
        .bus_rvalid_o (bus_rvalid_o),
        .mode_0_o     (mode_0),
        .period_0_o   (period_0),
        .thresh_a_0_o (thresh_a_0),
        .thresh_b_0_o (thresh_b_0),
        .step_0_o     (step_0),
        .mode_1_o     (mode_1),
        .period_1_o   (period_1),
        .thresh_a_1_o (thresh_a_1),
        .thresh_b_1_o (thresh_b_1),
        .step_1_o     (step_1)
    );

    pwm_channel pwm_channel_0_inst (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .mode_i     (mode_0),
        .period_i   (period_0),
        .thresh_a_i (thresh_a_0),
        .thresh_b_i (thresh_b_0),
        .step_i     (step_0),
        .pwm_o      (pwm0_o)
    );

    pwm_channel pwm_channel_1_inst (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .mode_i     (mode_1),
        .period_i   (period_1),
        .thresh_a_i (thresh_a_1),
        .thresh_b_i (thresh_b_1),
        .step_i     (step_1),
        .pwm_o      (pwm1_o)
    );

endmodule

`default_nettype wire

/* rtl/pwm_heartbeat_gen.sv */
// PWM generator whose duty ramps up and down between two thresholds, stepping once per period
`timescale 1ns/100ps
`default_nettype none

`include "pwm_defines.svh"

module pwm_heartbeat_gen (
    input  wire logic                       clk_i,
    input  wire logic                       rst_i,
    input  wire logic                       enable_i,
    input  wire logic [`PWM_RESOLUTION-1:0] period_i,
    input  wire logic [`PWM_RESOLUTION-1:0] thresh_a_i,
    input  wire logic [`PWM_RESOLUTION-1:0] thresh_b_i,
    input  wire logic [`PWM_STEP_WIDTH-1:0] step_i,
    output logic                            pwm_o
);

    typedef enum logic {
        DIR_RISING  = 1'b0,
        DIR_FALLING = 1'b1
    } dir_e;

    logic [`PWM_RESOLUTION-1:0] cnt_q;
    logic [`PWM_RESOLUTION-1:0] duty_q;
    dir_e                       dir_q;
    logic                       active_q; // duty loaded from thresh_a

    logic [`PWM_RESOLUTION:0]   cnt_sum;
    logic [`PWM_RESOLUTION:0]   step_ext;
    logic [`PWM_RESOLUTION:0]   up_sum;   // duty + step
    logic [`PWM_RESOLUTION:0]   down_lim; // thresh_a + step, at or below means we hit the floor
    logic                       period_zero;
    logic                       wrap;
    logic                       in_range;

    assign step_ext    = {{(`PWM_RESOLUTION+1-`PWM_STEP_WIDTH){1'b0}}, step_i};
    assign cnt_sum     = {1'b0, cnt_q} + (`PWM_RESOLUTION+1)'(`PWM_COUNT_STEP);
    assign up_sum      = {1'b0, duty_q} + step_ext;
    assign down_lim    = {1'b0, thresh_a_i} + step_ext;
    assign period_zero = (period_i == '0);
    assign wrap        = !period_zero && (cnt_sum >= {1'b0, period_i});

    always_ff @(posedge clk_i) begin
        if (rst_i || !enable_i) begin
            cnt_q    <= '0;
            duty_q   <= '0;
            dir_q    <= DIR_RISING;
            active_q <= 1'b0;
            pwm_o    <= 1'b0;
        end else begin
            if (wrap || period_zero) begin
                cnt_q <= '0;
            end else begin
                cnt_q <= cnt_sum[`PWM_RESOLUTION-1:0];
            end

            pwm_o <= (cnt_q < duty_q);

            if (!active_q) begin
                // first enabled cycle, start the ramp at the low threshold
                active_q <= 1'b1;
                duty_q   <= thresh_a_i;
                dir_q    <= DIR_RISING;
            end else if (wrap) begin
                if (dir_q == DIR_RISING) begin
                    if (up_sum >= {1'b0, thresh_b_i}) begin
                        duty_q <= thresh_b_i; // clamp and turn
                        dir_q  <= DIR_FALLING;
                    end else begin
                        duty_q <= up_sum[`PWM_RESOLUTION-1:0];
                    end
                end else begin
                    if ({1'b0, duty_q} <= down_lim) begin
                        duty_q <= thresh_a_i;
                        dir_q  <= DIR_RISING;
                    end else begin
                        duty_q <= duty_q - step_ext[`PWM_RESOLUTION-1:0];
                    end
                end
            end
        end
    end

    assign in_range = active_q && (thresh_a_i <= thresh_b_i) &&
                      (duty_q >= thresh_a_i) && (duty_q <= thresh_b_i);

    // once inside the band the ramp never leaves it while the thresholds hold still
    assert property (@(posedge clk_i) disable iff (rst_i)
        in_range |=> !active_q || !$stable(thresh_a_i) || !$stable(thresh_b_i) || in_range)
        else $error("heartbeat duty left the threshold band");

endmodule

`default_nettype wire

/* rtl/pwm_mode_pkg.sv */
// channel mode encoding, imported by the register file, the channels and the testbench
`default_nettype none

package pwm_mode_pkg;

    // value 3 is not defined and behaves like idle
    typedef enum logic [1:0] {
        MODE_IDLE      = 2'd0, // output held low
        MODE_STANDARD  = 2'd1, // fixed duty
        MODE_HEARTBEAT = 2'd2  // duty ramps between two thresholds
    } pwm_mode_e;

endpackage

`default_nettype wire

/* rtl/pwm_regfile.sv */
// bus-side register file of the PWM peripheral with write decode, channel settings and reads
`timescale 1ns/100ps
`default_nettype none

`include "pwm_defines.svh"

module pwm_regfile import pwm_mode_pkg::*, pwm_regmap_pkg::*; (
    input  wire logic                       clk_i,
    input  wire logic                       rst_i,
    input  wire logic [`PWM_ADDR_WIDTH-1:0] bus_addr_i,
    input  wire logic [`PWM_DATA_WIDTH-1:0] bus_wdata_i,
    input  wire logic                       bus_valid_i,
    input  wire logic                       bus_we_i,
    input  wire logic                       pwm0_i,
    input  wire logic                       pwm1_i,
    output logic      [`PWM_DATA_WIDTH-1:0] bus_rdata_o,
    output logic                            bus_rvalid_o,
    output pwm_mode_e                       mode_0_o,
    output logic      [`PWM_RESOLUTION-1:0] period_0_o,
    output logic      [`PWM_RESOLUTION-1:0] thresh_a_0_o,
    output logic      [`PWM_RESOLUTION-1:0] thresh_b_0_o,
    output logic      [`PWM_STEP_WIDTH-1:0] step_0_o,
    output pwm_mode_e                       mode_1_o,
    output logic      [`PWM_RESOLUTION-1:0] period_1_o,
    output logic      [`PWM_RESOLUTION-1:0] thresh_a_1_o,
    output logic      [`PWM_RESOLUTION-1:0] thresh_b_1_o,
    output logic      [`PWM_STEP_WIDTH-1:0] step_1_o
);

    pwm_reg_e                   addr;
    logic                       wr_en;
    logic                       rd_en;
    logic                       rd_hit;  // read at a defined offset
    logic [`PWM_DATA_WIDTH-1:0] rd_data;

    assign addr  = pwm_reg_e'(bus_addr_i);
    assign wr_en = bus_valid_i && bus_we_i;
    assign rd_en = bus_valid_i && !bus_we_i;

    // writes to REG_OUT and unknown offsets fall through untouched
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mode_0_o     <= MODE_IDLE;
            mode_1_o     <= MODE_IDLE;
            period_0_o   <= '0;
            period_1_o   <= '0;
            thresh_a_0_o <= '0;
            thresh_b_0_o <= '0;
            thresh_a_1_o <= '0;
            thresh_b_1_o <= '0;
            step_0_o     <= '0;
            step_1_o     <= '0;
        end else if (wr_en) begin
            case (addr)
                REG_CTRL0:     mode_0_o     <= pwm_mode_e'(bus_wdata_i[1:0]);
                REG_CTRL1:     mode_1_o     <= pwm_mode_e'(bus_wdata_i[1:0]);
                REG_PERIOD0:   period_0_o   <= bus_wdata_i[`PWM_RESOLUTION-1:0];
                REG_PERIOD1:   period_1_o   <= bus_wdata_i[`PWM_RESOLUTION-1:0];
                REG_THRESH0_A: thresh_a_0_o <= bus_wdata_i[`PWM_RESOLUTION-1:0];
                REG_THRESH0_B: thresh_b_0_o <= bus_wdata_i[`PWM_RESOLUTION-1:0];
                REG_THRESH1_A: thresh_a_1_o <= bus_wdata_i[`PWM_RESOLUTION-1:0];
                REG_THRESH1_B: thresh_b_1_o <= bus_wdata_i[`PWM_RESOLUTION-1:0];
                REG_STEP0:     step_0_o     <= bus_wdata_i[`PWM_STEP_WIDTH-1:0];
                REG_STEP1:     step_1_o     <= bus_wdata_i[`PWM_STEP_WIDTH-1:0];
                default:       ;
            endcase
        end
    end

    // read mux with narrow fields zero extended
    always_comb begin
        rd_hit  = 1'b1;
        rd_data = '0;
        case (addr)
            REG_CTRL0:     rd_data = {{(`PWM_DATA_WIDTH-2){1'b0}}, mode_0_o};
            REG_CTRL1:     rd_data = {{(`PWM_DATA_WIDTH-2){1'b0}}, mode_1_o};
            REG_PERIOD0:   rd_data = period_0_o;
            REG_PERIOD1:   rd_data = period_1_o;
            REG_THRESH0_A: rd_data = thresh_a_0_o;
            REG_THRESH0_B: rd_data = thresh_b_0_o;
            REG_THRESH1_A: rd_data = thresh_a_1_o;
            REG_THRESH1_B: rd_data = thresh_b_1_o;
            REG_STEP0:     rd_data = {{(`PWM_DATA_WIDTH-`PWM_STEP_WIDTH){1'b0}}, step_0_o};
            REG_STEP1:     rd_data = {{(`PWM_DATA_WIDTH-`PWM_STEP_WIDTH){1'b0}}, step_1_o};
            REG_OUT0:      rd_data = {{(`PWM_DATA_WIDTH-1){1'b0}}, pwm0_i}; // live pin
            REG_OUT1:      rd_data = {{(`PWM_DATA_WIDTH-1){1'b0}}, pwm1_i};
            default:       rd_hit  = 1'b0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            bus_rdata_o  <= '0;
            bus_rvalid_o <= 1'b0;
        end else begin
            bus_rvalid_o <= rd_en && rd_hit; // single cycle pulse
            if (rd_en && rd_hit) begin
                bus_rdata_o <= rd_data;
            end
        end
    end

    // the map is every word aligned offset up to REG_OUT1
    assert property (@(posedge clk_i) disable iff (rst_i)
        bus_rvalid_o |-> $past(bus_valid_i && !bus_we_i &&
                               (bus_addr_i[1:0] == 2'b00) && (bus_addr_i <= REG_OUT1)))
        else $error("read valid without a read strobe on the previous clock");

endmodule

`default_nettype wire

/* rtl/pwm_regmap_pkg.sv */
// bus register map of the PWM peripheral as byte offsets, used by the register file and testbench
`default_nettype none

`include "pwm_defines.svh"

package pwm_regmap_pkg;

    typedef enum logic [`PWM_ADDR_WIDTH-1:0] {
        REG_CTRL0     = 6'h00, // channel 0 mode
        REG_CTRL1     = 6'h04,
        REG_PERIOD0   = 6'h08,
        REG_PERIOD1   = 6'h0C,
        REG_THRESH0_A = 6'h10, // low threshold, also the standard duty
        REG_THRESH0_B = 6'h14, // high threshold, heartbeat only
        REG_THRESH1_A = 6'h18,
        REG_THRESH1_B = 6'h1C,
        REG_STEP0     = 6'h20,
        REG_STEP1     = 6'h24,
        REG_OUT0      = 6'h28, // read only, live pin level
        REG_OUT1      = 6'h2C
    } pwm_reg_e;

endpackage

`default_nettype wire

/* rtl/pwm_standard_gen.sv */
// fixed-duty PWM generator; instantiated once per channel and cleared while not enabled
`timescale 1ns/100ps
`default_nettype none

`include "pwm_defines.svh"

module pwm_standard_gen (
    input  wire logic                       clk_i,
    input  wire logic                       rst_i,
    input  wire logic                       enable_i,
    input  wire logic [`PWM_RESOLUTION-1:0] period_i,
    input  wire logic [`PWM_RESOLUTION-1:0] thresh_i,
    output logic                            pwm_o
);

    logic [`PWM_RESOLUTION-1:0] cnt_q;
    logic [`PWM_RESOLUTION:0]   cnt_sum; // one extra bit so the compare never overflows
    logic                       period_zero;
    logic                       wrap;

    assign cnt_sum     = {1'b0, cnt_q} + (`PWM_RESOLUTION+1)'(`PWM_COUNT_STEP);
    assign period_zero = (period_i == '0);
    assign wrap        = !period_zero && (cnt_sum >= {1'b0, period_i});

    always_ff @(posedge clk_i) begin
        if (rst_i || !enable_i) begin
            cnt_q <= '0;
            pwm_o <= 1'b0;
        end else begin
            if (wrap || period_zero) begin
                cnt_q <= '0;
            end else begin
                cnt_q <= cnt_sum[`PWM_RESOLUTION-1:0];
            end
            // thresh at or above period keeps this high for the whole period
            pwm_o <= !period_zero && (cnt_q < thresh_i);
        end
    end

    // a high output means the count sat below threshold one step ago or has just wrapped
    assert property (@(posedge clk_i) disable iff (rst_i)
        pwm_o && $stable(thresh_i) |->
            (cnt_q == '0) ||
            ({1'b0, cnt_q} < {1'b0, thresh_i} + (`PWM_RESOLUTION+1)'(`PWM_COUNT_STEP)))
        else $error("standard pwm high with counter at or above threshold");

endmodule

`default_nettype wire

/* sim/pwm_controller_tb.sv */
// directed testbench for the two-channel PWM peripheral; simulate pwm_controller_tb as top with tb.f
`timescale 1ns/100ps
`default_nettype none

`include "pwm_defines.svh"

module pwm_controller_tb import pwm_mode_pkg::*, pwm_regmap_pkg::*; ();

    localparam int AW = `PWM_ADDR_WIDTH;
    localparam int DW = `PWM_DATA_WIDTH;
    localparam int SETTLE = 30;   // cycles for a new setting to reach the pin
    localparam int STD0_PERIOD = 10;
    localparam int STD0_THRESH = 3;
    localparam int STD1_PERIOD = 7;
    localparam int STD1_THRESH = 5;
    localparam int HB_PERIOD = 12;
    localparam int HB_LOW = 2;
    localparam int HB_HIGH = 8;
    localparam int HB_STEP = 2;
    // budgets for readback, unmapped, standard, heartbeat and idle tests plus margin
    localparam int WATCHDOG_CYCLES = 2000 + 1000 + 4000 + 6000 + 4000 + 3000;

    logic          clk_i;
    logic          rst_i;
    logic [AW-1:0] bus_addr_i;
    logic [DW-1:0] bus_wdata_i;
    logic          bus_valid_i;
    logic          bus_we_i;
    logic [DW-1:0] bus_rdata_o;
    logic          bus_rvalid_o;
    logic          pwm0_o;
    logic          pwm1_o;

    logic [DW-1:0] shadow [0:15]; // expected register contents by word index
    integer        seed = 32'h59fa;
    int            test_errors;
    int            tests_passed;
    int            tests_failed;

    pwm_controller pwm_controller_inst (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .bus_addr_i   (bus_addr_i),
        .bus_wdata_i  (bus_wdata_i),
        .bus_valid_i  (bus_valid_i),
        .bus_we_i     (bus_we_i),
        .bus_rdata_o  (bus_rdata_o),
        .bus_rvalid_o (bus_rvalid_o),
        .pwm0_o       (pwm0_o),
        .pwm1_o       (pwm1_o)
    );

    // writable bits of each offset (zero for read only and unmapped)
    function automatic logic [DW-1:0] reg_mask(input logic [AW-1:0] off);
        case (off)
            REG_CTRL0, REG_CTRL1: reg_mask = 32'h3;
            REG_STEP0, REG_STEP1: reg_mask = 32'hfff;
            REG_PERIOD0, REG_PERIOD1, REG_THRESH0_A, REG_THRESH0_B,
            REG_THRESH1_A, REG_THRESH1_B: reg_mask = '1;
            default: reg_mask = '0;
        endcase
    endfunction

    // high cycles of a standard channel over whole periods
    function automatic int std_highs(input int period, input int thresh, input int periods);
        if (period == 0) begin
            std_highs = 0;
        end else if (thresh >= period) begin
            std_highs = period * periods;
        end else begin
            std_highs = thresh * periods;
        end
    endfunction

    task automatic bus_write(input logic [AW-1:0] off, input logic [DW-1:0] data);
        @(posedge clk_i);
        bus_addr_i  <= off;
        bus_wdata_i <= data;
        bus_valid_i <= 1'b1;
        bus_we_i    <= 1'b1;
        @(posedge clk_i);
        bus_valid_i <= 1'b0;
        bus_we_i    <= 1'b0;
    endtask

    task automatic bus_read(input logic [AW-1:0] off, output logic [DW-1:0] data,
                            output logic ok);
        int waited;
        @(posedge clk_i);
        bus_addr_i  <= off;
        bus_valid_i <= 1'b1;
        bus_we_i    <= 1'b0;
        @(posedge clk_i);
        bus_valid_i <= 1'b0;
        ok     = 1'b0;
        data   = '0;
        waited = 0;
        while (!ok && waited < 4) begin
            @(negedge clk_i); // rvalid sampled mid cycle
            if (bus_rvalid_o) begin
                ok   = 1'b1;
                data = bus_rdata_o;
            end
            waited++;
        end
    endtask

    task automatic write_reg(input logic [AW-1:0] off, input logic [DW-1:0] data);
        bus_write(off, data);
        if (reg_mask(off) != '0) begin
            shadow[off[AW-1:2]] = data & reg_mask(off);
        end
    endtask

    task automatic read_check(input string test, input logic [AW-1:0] off,
                              input logic [DW-1:0] exp);
        logic [DW-1:0] data;
        logic          ok;
        bus_read(off, data, ok);
        if (!ok) begin
            $display("%s: no read response from offset 0x%02h within 4 cycles", test, off);
            test_errors++;
        end else if (data !== exp) begin
            $display("Fail %s offset 0x%02h: expected 0x%08h actual 0x%08h",
                     test, off, exp, data);
            test_errors++;
        end
    endtask

    task automatic value_check(input string test, input string what, input int exp,
                               input int act);
        if (exp != act) begin
            $display("Fail %s %s: expected %0d actual %0d", test, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic count_highs(input int ch, input int cycles, output int n);
        n = 0;
        repeat (cycles) begin
            @(negedge clk_i);
            if ((ch == 0) ? pwm0_o : pwm1_o) begin
                n++;
            end
        end
    endtask

    // width of the next complete high pulse on pwm0_o
    task automatic measure_pulse(output int width);
        int guard;
        width = 0;
        guard = 0;
        @(negedge clk_i);
        while (pwm0_o && guard < 100) begin // skip a pulse already under way
            @(negedge clk_i);
            guard++;
        end
        while (!pwm0_o && guard < 100) begin
            @(negedge clk_i);
            guard++;
        end
        while (pwm0_o && guard < 100) begin
            width++;
            @(negedge clk_i);
            guard++;
        end
    endtask

    // pin held at a known level and the same level through REG_OUT
    task automatic out_check(input string test, input int ch, input logic level);
        logic pin;
        @(negedge clk_i);
        pin = (ch == 0) ? pwm0_o : pwm1_o;
        if (pin !== level) begin
            $display("Fail %s pwm%0d pin: expected %0b actual %0b", test, ch, level, pin);
            test_errors++;
        end
        read_check(test, (ch == 0) ? REG_OUT0 : REG_OUT1, {{(DW-1){1'b0}}, level});
    endtask

    task automatic end_test(input string test);
        if (test_errors == 0) begin
            $display("%s: passed", test);
            tests_passed++;
        end else begin
            $display("%s: failed with %0d errors", test, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    task automatic reset_and_readback();
        string test;
        test = "reset_and_readback";
        for (int off = 0; off <= 'h2c; off += 4) begin
            read_check(test, AW'(off), '0);
        end
        for (int off = 0; off <= 'h24; off += 4) begin
            write_reg(AW'(off), $random(seed));
        end
        for (int off = 0; off <= 'h24; off += 4) begin
            read_check(test, AW'(off), shadow[off / 4]);
        end
        write_reg(REG_CTRL0, MODE_IDLE); // pin 0 held low from here
        write_reg(REG_CTRL1, MODE_IDLE);
        repeat (4) @(negedge clk_i);
        read_check(test, REG_OUT0, '0);
        write_reg(REG_OUT0, '1);
        read_check(test, REG_OUT0, '0);
        end_test(test);
    endtask

    task automatic unmapped_offsets();
        string         test;
        logic [DW-1:0] data;
        logic [DW-1:0] held;
        logic          ok;
        test = "unmapped_offsets";
        held = bus_rdata_o;
        bus_read(6'h30, data, ok);
        if (ok) begin
            $display("%s: read at offset 0x30 gave a read response", test);
            test_errors++;
        end
        if (bus_rdata_o !== held) begin
            $display("Fail %s rdata after 0x30 read: expected 0x%08h actual 0x%08h",
                     test, held, bus_rdata_o);
            test_errors++;
        end
        write_reg(6'h30, $random(seed));
        for (int off = 0; off <= 'h24; off += 4) begin
            read_check(test, AW'(off), shadow[off / 4]);
        end
        end_test(test);
    endtask

    task automatic standard_duty();
        string test;
        int    n;
        test = "standard_duty";
        write_reg(REG_PERIOD0, STD0_PERIOD);
        write_reg(REG_THRESH0_A, STD0_THRESH);
        write_reg(REG_PERIOD1, STD1_PERIOD);
        write_reg(REG_THRESH1_A, STD1_THRESH);
        write_reg(REG_CTRL0, MODE_STANDARD);
        write_reg(REG_CTRL1, MODE_STANDARD);
        repeat (SETTLE) @(negedge clk_i);
        count_highs(0, 4 * STD0_PERIOD, n);
        value_check(test, "pwm0 highs", std_highs(STD0_PERIOD, STD0_THRESH, 4), n);
        count_highs(1, 4 * STD1_PERIOD, n);
        value_check(test, "pwm1 highs", std_highs(STD1_PERIOD, STD1_THRESH, 4), n);
        write_reg(REG_THRESH0_A, 0);
        repeat (SETTLE) @(negedge clk_i);
        count_highs(0, 4 * STD0_PERIOD, n);
        value_check(test, "pwm0 highs at threshold 0", 0, n);
        write_reg(REG_THRESH0_A, STD0_PERIOD);
        repeat (SETTLE) @(negedge clk_i);
        count_highs(0, 4 * STD0_PERIOD, n);
        value_check(test, "pwm0 highs at full duty", std_highs(STD0_PERIOD, STD0_PERIOD, 4), n);
        end_test(test);
    endtask

    task automatic heartbeat_ramp();
        string test;
        int    prev;
        int    width;
        int    exp;
        bit    rising;
        test = "heartbeat_ramp";
        write_reg(REG_CTRL0, MODE_IDLE); // clear the generators first
        write_reg(REG_PERIOD0, HB_PERIOD);
        write_reg(REG_THRESH0_A, HB_LOW);
        write_reg(REG_THRESH0_B, HB_HIGH);
        write_reg(REG_STEP0, HB_STEP);
        write_reg(REG_CTRL0, MODE_HEARTBEAT);
        measure_pulse(width); // may be cut short by the enable
        measure_pulse(prev);
        rising = (prev < HB_HIGH); // ramp starts upward from thresh_a
        for (int i = 0; i < 10; i++) begin
            if (rising && prev + HB_STEP >= HB_HIGH) begin
                exp    = HB_HIGH;
                rising = 1'b0;
            end else if (rising) begin
                exp = prev + HB_STEP;
            end else if (prev - HB_STEP <= HB_LOW) begin
                exp    = HB_LOW;
                rising = 1'b1;
            end else begin
                exp = prev - HB_STEP;
            end
            measure_pulse(width);
            value_check(test, "pulse width", exp, width);
            prev = width;
        end
        end_test(test);
    endtask

    task automatic idle_and_readback();
        string test;
        int    n;
        test = "idle_and_readback";
        write_reg(REG_CTRL0, MODE_IDLE); // channel 0 still ramping
        repeat (4) @(negedge clk_i);
        count_highs(0, 2 * HB_PERIOD, n);
        value_check(test, "pwm0 highs in idle", 0, n);
        out_check(test, 0, 1'b0);
        write_reg(REG_CTRL0, MODE_STANDARD);
        repeat (SETTLE) @(negedge clk_i);
        count_highs(0, 2 * HB_PERIOD, n);
        value_check(test, "pwm0 highs in standard", std_highs(HB_PERIOD, HB_LOW, 2), n);
        write_reg(REG_CTRL0, 3); // spare mode code
        repeat (4) @(negedge clk_i);
        count_highs(0, 2 * HB_PERIOD, n);
        value_check(test, "pwm0 highs in mode 3", 0, n);
        read_check(test, REG_CTRL0, shadow[REG_CTRL0 >> 2]);
        out_check(test, 0, 1'b0);
        write_reg(REG_THRESH1_A, STD1_PERIOD + 2);
        repeat (SETTLE) @(negedge clk_i);
        count_highs(1, 2 * STD1_PERIOD, n);
        value_check(test, "pwm1 highs at full duty",
                    std_highs(STD1_PERIOD, STD1_PERIOD + 2, 2), n);
        out_check(test, 1, 1'b1);
        end_test(test);
    endtask

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("watchdog: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        rst_i       <= 1'b1;
        bus_addr_i  <= '0;
        bus_wdata_i <= '0;
        bus_valid_i <= 1'b0;
        bus_we_i    <= 1'b0;
        for (int i = 0; i < 16; i++) begin
            shadow[i] = '0;
        end
        repeat (4) @(posedge clk_i);
        rst_i <= 1'b0;
        @(negedge clk_i);
        reset_and_readback();
        unmapped_offsets();
        standard_duty();
        heartbeat_ramp();
        idle_and_readback();
        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+include
rtl/pwm_mode_pkg.sv
rtl/pwm_regmap_pkg.sv
rtl/pwm_standard_gen.sv
rtl/pwm_heartbeat_gen.sv
rtl/pwm_channel.sv
rtl/pwm_regfile.sv
rtl/pwm_controller.sv
sim/pwm_controller_tb.sv
